// File: src/trap_pkg.sv
package trap_pkg;

  typedef logic [31:0] xlen_t;                     // Machine data word
  typedef logic [11:0] csr_addr_t;                 // CSR address as found in the instruction
  typedef logic [4:0]  cause_t;                    // Exception code field of mcause

  // CSR operation as the core presents it after decode
  typedef enum logic [1:0] {
    csr_op_write = 2'd0,                           // Plain write of the source operand
    csr_op_set   = 2'd1,                           // Set the bits that are one in the operand
    csr_op_clear = 2'd2                            // Clear the bits that are one in the operand
  } csr_op_e;

  localparam csr_addr_t CSR_MSTATUS  = 12'h300;
  localparam csr_addr_t CSR_MIE      = 12'h304;
  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;
  localparam csr_addr_t CSR_MIP      = 12'h344;

  localparam int MSTATUS_MIE_BIT  = 3;             // Global machine interrupt enable
  localparam int MSTATUS_MPIE_BIT = 7;             // Enable state saved on trap entry

  localparam int IRQ_MSI_BIT = 3;                  // Software interrupt in mie and mip
  localparam int IRQ_MTI_BIT = 7;                  // Timer interrupt in mie and mip
  localparam int IRQ_MEI_BIT = 11;                 // External interrupt in mie and mip

  localparam cause_t CAUSE_MSI = 5'd3;
  localparam cause_t CAUSE_MTI = 5'd7;
  localparam cause_t CAUSE_MEI = 5'd11;

  localparam int MCAUSE_IRQ_BIT = 31;              // Set in mcause for every interrupt

  // Bits that keep a written value, everything else reads as zero
  localparam xlen_t MSTATUS_WMASK = (xlen_t'(1) << MSTATUS_MIE_BIT)
                                  | (xlen_t'(1) << MSTATUS_MPIE_BIT);
  localparam xlen_t MIE_WMASK     = (xlen_t'(1) << IRQ_MSI_BIT)
                                  | (xlen_t'(1) << IRQ_MTI_BIT)
                                  | (xlen_t'(1) << IRQ_MEI_BIT);
  localparam xlen_t MEPC_WMASK    = 32'hFFFF_FFFC;  // Instruction addresses are word aligned
  localparam xlen_t MTVEC_WMASK   = 32'hFFFF_FFFD;  // Mode bit 0 kept and bit 1 reserved

endpackage

// File: src/clint_pkg.sv
package clint_pkg;

  typedef logic [15:0] axil_addr_t;                // Byte offset into the CLINT window
  typedef logic [31:0] axil_data_t;                // Bus data word
  typedef logic [1:0]  axil_resp_t;                // Write and read response code
  typedef logic [63:0] mtime_t;                    // Full width of mtime and mtimecmp

  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  // Register map of the CLINT with a single hart
  localparam axil_addr_t CLINT_MSIP        = 16'h0000;
  localparam axil_addr_t CLINT_MTIMECMP_LO = 16'h4000;
  localparam axil_addr_t CLINT_MTIMECMP_HI = 16'h4004;
  localparam axil_addr_t CLINT_MTIME_LO    = 16'hBFF8;
  localparam axil_addr_t CLINT_MTIME_HI    = 16'hBFFC;

  localparam int AXIL_STRB_W = 4;                  // One strobe per byte of the data word

  // Compare value out of reach so that no timer interrupt fires after reset
  localparam mtime_t MTIMECMP_RESET = 64'hFFFF_FFFF_FFFF_FFFF;

endpackage

// File: src/trap_if.sv
`timescale 1ns/10ps

// Link between the CSR file and the interrupt control block
interface trap_if import trap_pkg::*; ();

  logic   global_ie;                               // mstatus.MIE
  xlen_t  mie_q;                                   // Interrupt enable register
  xlen_t  mip_q;                                   // Registered pending sources
  xlen_t  mtvec_q;                                 // Trap vector base and mode
  logic   trap_take;                               // Trap is taken at the next edge
  cause_t trap_cause;                              // Code of the winning interrupt

  modport csr (
    output global_ie, mie_q, mip_q, mtvec_q,
    input  trap_take, trap_cause
  );

  modport ctrl (
    input  global_ie, mie_q, mip_q, mtvec_q,
    output trap_take, trap_cause
  );

endinterface

// File: src/csr_file.sv
`timescale 1ns/10ps

module csr_file import trap_pkg::*; (
  input  logic      clk,
  input  logic      reset_n,
  input  logic      csr_valid,                     // Decoded CSR instruction this cycle
  input  csr_op_e   csr_op,
  input  csr_addr_t csr_addr,
  input  xlen_t     csr_wdata,
  output xlen_t     csr_rdata,
  output logic      csr_illegal,
  input  xlen_t     retire_pc,                     // PC saved into mepc on trap entry
  input  logic      mret,
  input  logic      irq_msi,
  input  logic      irq_mti,
  input  logic      irq_external,
  output xlen_t     mret_target,
  trap_if.csr       tif
);

  xlen_t mstatus_q;                                // Only MIE and MPIE are implemented
  xlen_t mie_q;
  xlen_t mtvec_q;
  xlen_t mscratch_q;
  xlen_t mepc_q;
  xlen_t mcause_q;
  xlen_t mip_q;                                    // Sampled sources with one cycle delay
  xlen_t csr_wval;                                 // Value after the write, set or clear
  xlen_t mip_next;
  logic  csr_we;                                   // CSR write survives trap and mret

  // Read mux is purely combinational on the address
  always_comb begin
    csr_illegal = 1'b0;
    case (csr_addr)
      CSR_MSTATUS:  csr_rdata = mstatus_q;
      CSR_MIE:      csr_rdata = mie_q;
      CSR_MTVEC:    csr_rdata = mtvec_q;
      CSR_MSCRATCH: csr_rdata = mscratch_q;
      CSR_MEPC:     csr_rdata = mepc_q;
      CSR_MCAUSE:   csr_rdata = mcause_q;
      CSR_MIP:      csr_rdata = mip_q;
      default: begin
        csr_rdata   = '0;                          // Unknown CSR reads as zero
        csr_illegal = 1'b1;                        // and is flagged to the core
      end
    endcase
  end

  // Read-modify-write value before the per-register mask
  always_comb begin
    case (csr_op)
      csr_op_write: csr_wval = csr_wdata;
      csr_op_set:   csr_wval = csr_rdata | csr_wdata;
      csr_op_clear: csr_wval = csr_rdata & ~csr_wdata;
      default:      csr_wval = csr_rdata;          // Encoding 3 leaves the register unchanged
    endcase
  end

  // Trap entry wins over mret and mret wins over a CSR write
  assign csr_we = csr_valid && !tif.trap_take && !mret && !csr_illegal;

  // Pending sources in their standard mip positions
  always_comb begin
    mip_next               = '0;
    mip_next[IRQ_MSI_BIT]  = irq_msi;
    mip_next[IRQ_MTI_BIT]  = irq_mti;
    mip_next[IRQ_MEI_BIT]  = irq_external;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mstatus_q  <= '0;
      mie_q      <= '0;
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mip_q      <= '0;
    end else begin
      mip_q <= mip_next;                           // Sampled every cycle regardless of traps
      if (tif.trap_take) begin
        mepc_q                       <= retire_pc & MEPC_WMASK;
        mcause_q                     <= '0;
        mcause_q[MCAUSE_IRQ_BIT]     <= 1'b1;      // Interrupt flag
        mcause_q[$bits(cause_t)-1:0] <= tif.trap_cause;
        mstatus_q[MSTATUS_MPIE_BIT]  <= mstatus_q[MSTATUS_MIE_BIT];
        mstatus_q[MSTATUS_MIE_BIT]   <= 1'b0;      // Handler runs with interrupts off
      end else if (mret) begin
        mstatus_q[MSTATUS_MIE_BIT]   <= mstatus_q[MSTATUS_MPIE_BIT];
        mstatus_q[MSTATUS_MPIE_BIT]  <= 1'b1;
      end else if (csr_we) begin
        case (csr_addr)
          CSR_MSTATUS:  mstatus_q  <= csr_wval & MSTATUS_WMASK;
          CSR_MIE:      mie_q      <= csr_wval & MIE_WMASK;
          CSR_MTVEC:    mtvec_q    <= csr_wval & MTVEC_WMASK;
          CSR_MSCRATCH: mscratch_q <= csr_wval;
          CSR_MEPC:     mepc_q     <= csr_wval & MEPC_WMASK;
          CSR_MCAUSE:   mcause_q   <= csr_wval;
          default: ;                               // mip is read-only
        endcase
      end
    end
  end

  assign mret_target = mepc_q;                     // Return address is always on display

  // State the interrupt control block decides on
  assign tif.global_ie = mstatus_q[MSTATUS_MIE_BIT];
  assign tif.mie_q     = mie_q;
  assign tif.mip_q     = mip_q;
  assign tif.mtvec_q   = mtvec_q;

endmodule

// File: src/int_control.sv
`timescale 1ns/10ps

module int_control import trap_pkg::*; (
  input  logic  retire_valid,                      // An instruction retires this cycle
  output logic  trap_taken,
  output xlen_t trap_target,
  trap_if.ctrl  tif
);

  xlen_t  pending;                                 // Pending and individually enabled
  logic   any_pending;
  cause_t cause;
  xlen_t  vec_base;

  assign pending = tif.mie_q & tif.mip_q;

  // Fixed priority MEI then MSI then MTI
  always_comb begin
    any_pending = 1'b1;
    if (pending[IRQ_MEI_BIT]) begin
      cause = CAUSE_MEI;
    end else if (pending[IRQ_MSI_BIT]) begin
      cause = CAUSE_MSI;
    end else if (pending[IRQ_MTI_BIT]) begin
      cause = CAUSE_MTI;
    end else begin
      cause       = '0;
      any_pending = 1'b0;                          // Nothing to take
    end
  end

  // Interrupts are taken only at an instruction boundary
  assign trap_taken = retire_valid && tif.global_ie && any_pending;

  // Base address with the two mode bits dropped
  assign vec_base = {tif.mtvec_q[31:2], 2'b00};

  // Vectored mode jumps to base plus four times the cause
  always_comb begin
    if (tif.mtvec_q[0]) begin
      trap_target = vec_base + (xlen_t'(cause) << 2);
    end else begin
      trap_target = vec_base;                      // Direct mode uses one entry point
    end
  end

  assign tif.trap_take  = trap_taken;
  assign tif.trap_cause = cause;

endmodule

// File: src/clint_axil.sv
`timescale 1ns/10ps

module clint_axil import clint_pkg::*; (
  input  logic             clk,
  input  logic             reset_n,
  input  axil_addr_t       awaddr,
  input  logic             awvalid,
  output logic             awready,
  input  axil_data_t       wdata,
  input  logic [3:0]       wstrb,
  input  logic             wvalid,
  output logic             wready,
  output axil_resp_t       bresp,
  output logic             bvalid,
  input  logic             bready,
  input  axil_addr_t       araddr,
  input  logic             arvalid,
  output logic             arready,
  output axil_data_t       rdata,
  output axil_resp_t       rresp,
  output logic             rvalid,
  input  logic             rready,
  output logic             msip,                   // Software interrupt request
  output logic             mtip                    // Timer interrupt request
);

  mtime_t     mtime;                               // Free-running time base
  mtime_t     mtimecmp;
  logic       wr_fire;                             // Address and data accepted together
  logic       rd_fire;
  logic       wr_hit;                              // Write offset is in the register map
  axil_data_t rd_val;                              // Read mux output
  logic       rd_hit;

  // Byte lanes with a strobe take the new data
  function automatic axil_data_t merge_strb(axil_data_t old_val, axil_data_t new_val,
                                            logic [AXIL_STRB_W-1:0] strb);
    axil_data_t res;
    res = old_val;
    for (int i = 0; i < AXIL_STRB_W; i++) begin
      if (strb[i]) res[8*i +: 8] = new_val[8*i +: 8];
    end
    return res;
  endfunction

  // A response still waiting for its ready holds off the next request
  assign awready = !bvalid;
  assign wready  = !bvalid;
  assign arready = !rvalid;
  assign wr_fire = awvalid && wvalid && !bvalid;
  assign rd_fire = arvalid && !rvalid;

  always_comb begin
    case (awaddr)
      CLINT_MSIP, CLINT_MTIMECMP_LO, CLINT_MTIMECMP_HI,
      CLINT_MTIME_LO, CLINT_MTIME_HI: wr_hit = 1'b1;
      default:                        wr_hit = 1'b0;
    endcase
  end

  always_comb begin
    rd_hit = 1'b1;
    case (araddr)
      CLINT_MSIP:        rd_val = axil_data_t'(msip);
      CLINT_MTIMECMP_LO: rd_val = mtimecmp[31:0];
      CLINT_MTIMECMP_HI: rd_val = mtimecmp[63:32];
      CLINT_MTIME_LO:    rd_val = mtime[31:0];
      CLINT_MTIME_HI:    rd_val = mtime[63:32];
      default: begin
        rd_val = '0;                               // Unmapped reads return zero
        rd_hit = 1'b0;
      end
    endcase
  end

  // Timer registers and handshake state
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mtime    <= '0;
      mtimecmp <= MTIMECMP_RESET;
      msip     <= 1'b0;
      mtip     <= 1'b0;
      bvalid   <= 1'b0;
      bresp    <= RESP_OKAY;
      rvalid   <= 1'b0;
      rdata    <= '0;
      rresp    <= RESP_OKAY;
    end else begin
      mtime <= mtime + 64'd1;                      // Counts one per clock
      mtip  <= (mtime >= mtimecmp);                // Level request while the compare holds
      if (wr_fire) begin
        case (awaddr)
          CLINT_MSIP:        msip <= wstrb[0] ? wdata[0] : msip;
          CLINT_MTIMECMP_LO: mtimecmp[31:0]  <= merge_strb(mtimecmp[31:0], wdata, wstrb);
          CLINT_MTIMECMP_HI: mtimecmp[63:32] <= merge_strb(mtimecmp[63:32], wdata, wstrb);
          default: ;                               // mtime is read-only and holes are ignored
        endcase
      end
      if (wr_fire) begin
        bvalid <= 1'b1;
        bresp  <= wr_hit ? RESP_OKAY : RESP_SLVERR;
      end else if (bready) begin
        bvalid <= 1'b0;                            // Response taken by the master
      end
      if (rd_fire) begin
        rvalid <= 1'b1;
        rdata  <= rd_val;
        rresp  <= rd_hit ? RESP_OKAY : RESP_SLVERR;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

endmodule

// File: src/trap_unit_top.sv
`timescale 1ns/10ps

module trap_unit_top import trap_pkg::*, clint_pkg::*; (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       csr_valid,
  input  csr_op_e    csr_op,
  input  csr_addr_t  csr_addr,
  input  xlen_t      csr_wdata,
  output xlen_t      csr_rdata,
  output logic       csr_illegal,
  input  logic       retire_valid,
  input  xlen_t      retire_pc,
  input  logic       mret,
  input  logic       irq_external,                 // Level request from the platform
  output logic       trap_taken,
  output xlen_t      trap_target,
  output xlen_t      mret_target,
  input  axil_addr_t awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  axil_data_t wdata,
  input  logic [3:0] wstrb,
  input  logic       wvalid,
  output logic       wready,
  output axil_resp_t bresp,
  output logic       bvalid,
  input  logic       bready,
  input  axil_addr_t araddr,
  input  logic       arvalid,
  output logic       arready,
  output axil_data_t rdata,
  output axil_resp_t rresp,
  output logic       rvalid,
  input  logic       rready
);

  logic msip;                                      // CLINT software request into mip
  logic mtip;                                      // CLINT timer request into mip

  trap_if u_tif ();

  csr_file u_csr_file (
    .clk, .reset_n,
    .csr_valid, .csr_op, .csr_addr, .csr_wdata, .csr_rdata, .csr_illegal,
    .retire_pc, .mret,
    .irq_msi (msip),
    .irq_mti (mtip),
    .irq_external, .mret_target,
    .tif     (u_tif.csr)
  );

  int_control u_int_control (
    .retire_valid, .trap_taken, .trap_target,
    .tif (u_tif.ctrl)
  );

  clint_axil u_clint_axil (
    .clk, .reset_n,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .msip, .mtip
  );

endmodule

// File: verification/trap_unit_properties.sv
`timescale 1ns/10ps

module trap_unit_properties import trap_pkg::*, clint_pkg::*; (
  input logic       clk,
  input logic       reset_n,
  input logic       bvalid,
  input logic       bready,
  input axil_resp_t bresp,
  input logic       rvalid,
  input logic       rready,
  input axil_data_t rdata,
  input axil_resp_t rresp,
  input logic       retire_valid,
  input logic       trap_taken,
  input xlen_t      mstatus                        // Internal mstatus of the CSR file
);

  // A write response stays put until the master takes it
  assert property (@(posedge clk) disable iff (!reset_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else $error("bvalid or bresp changed before bready");

  // Same rule for the read channel payload
  assert property (@(posedge clk) disable iff (!reset_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else $error("rvalid or read payload changed before rready");

  // Interrupts are only taken on a retiring instruction
  assert property (@(posedge clk) disable iff (!reset_n) trap_taken |-> retire_valid)
    else $error("trap_taken without retire_valid");

  // The handler starts with global interrupts off
  assert property (@(posedge clk) disable iff (!reset_n)
    trap_taken |=> !mstatus[MSTATUS_MIE_BIT])
    else $error("mstatus.MIE still set after trap entry");

endmodule

bind trap_unit_top trap_unit_properties u_trap_unit_properties (
  .clk, .reset_n, .bvalid, .bready, .bresp, .rvalid, .rready, .rdata, .rresp,
  .retire_valid, .trap_taken,
  .mstatus (u_csr_file.mstatus_q)
);

// File: verification/tb_trap_unit.sv
`timescale 1ns/10ps

module tb_trap_unit import trap_pkg::*, clint_pkg::*; ();

  localparam int NUM_OPS = 200;                    // Upper bound on bus and CSR operations

  logic clk, reset_n, csr_valid, csr_illegal, retire_valid, mret, irq_external;
  logic trap_taken, awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [3:0] wstrb;
  csr_op_e csr_op;
  csr_addr_t csr_addr;
  xlen_t csr_wdata, csr_rdata, retire_pc, trap_target, mret_target;
  axil_addr_t awaddr, araddr;
  axil_data_t wdata, rdata;
  axil_resp_t bresp, rresp;

  logic [31:0] seed;                               // LCG state
  int errors, checks, cycles;
  xlen_t m_mstatus, m_mie, m_mtvec, m_mscratch, m_mepc, m_mcause;  // Reference CSRs
  logic m_msip;
  mtime_t m_cmp;

  trap_unit_top u_trap_unit_top (.*);

  always #50 clk = ~clk;
  always @(posedge clk) if (reset_n) cycles++;     // Model time base, mtime can not run ahead

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic check_xlen(string name, xlen_t got, xlen_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_cause(string name, cause_t got, cause_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bus(string name, axil_data_t got, axil_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_resp(string name, axil_resp_t got, axil_resp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic tick();
    @(posedge clk);
    #5;                                            // Inputs change well away from the edge
  endtask

  function automatic logic csr_known(csr_addr_t a);
    return a inside {CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE,
                     CSR_MIP};
  endfunction

  // mip stays zero in the CSR test since no source is active then
  function automatic xlen_t model_read(csr_addr_t a);
    case (a)
      CSR_MSTATUS:  return m_mstatus;
      CSR_MIE:      return m_mie;
      CSR_MTVEC:    return m_mtvec;
      CSR_MSCRATCH: return m_mscratch;
      CSR_MEPC:     return m_mepc;
      CSR_MCAUSE:   return m_mcause;
      default:      return '0;
    endcase
  endfunction

  task automatic csr_read_check(csr_addr_t a);
    csr_addr = a;
    #1;
    check_xlen($sformatf("csr_rdata[%h]", a), csr_rdata, model_read(a));
    check_bit("csr_illegal", csr_illegal, !csr_known(a));
    tick();
  endtask

  task automatic csr_access(csr_op_e op, csr_addr_t a, xlen_t d);
    xlen_t nv;
    case (op)
      csr_op_set:   nv = model_read(a) | d;
      csr_op_clear: nv = model_read(a) & ~d;
      default:      nv = d;
    endcase
    csr_valid = 1'b1;
    csr_op    = op;
    csr_addr  = a;
    csr_wdata = d;
    tick();
    csr_valid = 1'b0;
    case (a)                                       // Write masks of the register map
      CSR_MSTATUS:  m_mstatus  = nv & 32'h0000_0088;
      CSR_MIE:      m_mie      = nv & 32'h0000_0888;
      CSR_MTVEC:    m_mtvec    = nv & ~32'h2;
      CSR_MSCRATCH: m_mscratch = nv;
      CSR_MEPC:     m_mepc     = nv & ~32'h3;
      CSR_MCAUSE:   m_mcause   = nv;
      default: ;
    endcase
  endtask

  task automatic axi_write(axil_addr_t a, axil_data_t d, logic [3:0] s, axil_resp_t exp);
    int n;
    int stall;
    awaddr = a;
    wdata  = d;
    wstrb  = s;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    for (n = 0; n < 20; n++) begin
      #1;
      if (awready && wready) break;
      tick();
    end
    if (n == 20) begin
      errors++;
      $display("Write address and data never accepted at offset %h", a);
    end
    tick();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    for (n = 0; n < 20; n++) begin
      #1;
      if (bvalid) break;
      tick();
    end
    if (n == 20) begin
      errors++;
      $display("No write response for offset %h", a);
    end else check_resp("bresp", bresp, exp);
    stall = next_rand() % 3;                       // Master keeps bready low for a while
    repeat (stall) begin
      tick();
      #1;
      check_bit("bvalid under back-pressure", bvalid, 1'b1);
      check_bit("awready under back-pressure", awready, 1'b0);
      check_bit("wready under back-pressure", wready, 1'b0);
    end
    tick();
    bready = 1'b1;
    tick();                                        // Response retires at this edge
    bready = 1'b0;
    if (exp == RESP_OKAY && a == CLINT_MSIP && s[0]) m_msip = d[0];
    for (int i = 0; i < 4; i++) begin
      if (exp == RESP_OKAY && s[i] && a == CLINT_MTIMECMP_LO) m_cmp[8*i +: 8] = d[8*i +: 8];
      if (exp == RESP_OKAY && s[i] && a == CLINT_MTIMECMP_HI) m_cmp[32+8*i +: 8] = d[8*i +: 8];
    end
  endtask

  task automatic axi_read(axil_addr_t a, axil_resp_t exp, output axil_data_t d);
    int n;
    int stall;
    araddr  = a;
    arvalid = 1'b1;
    for (n = 0; n < 20; n++) begin
      #1;
      if (arready) break;
      tick();
    end
    if (n == 20) begin
      errors++;
      $display("Read address never accepted at offset %h", a);
    end
    tick();
    arvalid = 1'b0;
    d = '0;
    for (n = 0; n < 20; n++) begin
      #1;
      if (rvalid) break;
      tick();
    end
    if (n == 20) begin
      errors++;
      $display("No read response for offset %h", a);
    end else begin
      check_resp("rresp", rresp, exp);
      d = rdata;
    end
    stall = next_rand() % 3;                       // Master keeps rready low for a while
    repeat (stall) begin
      tick();
      #1;
      check_bit("rvalid under back-pressure", rvalid, 1'b1);
      check_bit("arready under back-pressure", arready, 1'b0);
    end
    tick();
    rready = 1'b1;
    tick();
    rready = 1'b0;
  endtask

  task automatic take_trap(xlen_t pc, cause_t cause);
    xlen_t base;
    int n;
    base = m_mtvec & ~32'h3;
    retire_pc    = pc;
    retire_valid = 1'b1;
    for (n = 0; n < 20; n++) begin
      #1;
      if (trap_taken) break;
      tick();
    end
    if (n == 20) begin
      errors++;
      $display("No trap taken for cause %0d", cause);
    end else begin
      check_xlen("trap_target", trap_target, m_mtvec[0] ? base + 4 * cause : base);
    end
    tick();
    retire_valid = 1'b0;
    m_mepc    = pc & ~32'h3;
    m_mcause  = 32'h8000_0000 | cause;
    m_mstatus = m_mstatus[3] ? 32'h80 : 32'h0;     // MIE moves into MPIE
    csr_addr  = CSR_MCAUSE;
    #1;
    check_cause("mcause code", cause_t'(csr_rdata), cause);
    csr_read_check(CSR_MEPC);
    csr_read_check(CSR_MCAUSE);
    csr_read_check(CSR_MSTATUS);
  endtask

  task automatic do_mret();
    check_xlen("mret_target", mret_target, m_mepc);
    mret = 1'b1;
    tick();
    mret = 1'b0;
    m_mstatus = 32'h80 | (m_mstatus[7] ? 32'h8 : 32'h0);
    csr_read_check(CSR_MSTATUS);
  endtask

  initial begin
    #(NUM_OPS * 20 * 100);
    $display("Watchdog expired before the tests completed");
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [31:0] d;
    axil_data_t rd;
    axil_data_t last_time;
    axil_addr_t a;
    csr_addr_t ca;
    clk          = 1'b0;
    reset_n      = 1'b0;
    csr_valid    = 1'b0;
    csr_op       = csr_op_write;
    csr_addr     = '0;
    csr_wdata    = '0;
    retire_valid = 1'b0;
    retire_pc    = '0;
    mret         = 1'b0;
    irq_external = 1'b0;
    awaddr       = '0;
    awvalid      = 1'b0;
    wdata        = '0;
    wstrb        = '0;
    wvalid       = 1'b0;
    bready       = 1'b0;
    araddr       = '0;
    arvalid      = 1'b0;
    rready       = 1'b0;
    seed         = 32'hcc26;
    errors       = 0;
    checks       = 0;
    cycles       = 0;
    last_time    = '0;
    m_mstatus    = '0;
    m_mie        = '0;
    m_mtvec      = '0;
    m_mscratch   = '0;
    m_mepc       = '0;
    m_mcause     = '0;
    m_msip       = 1'b0;
    m_cmp        = '1;
    repeat (3) @(posedge clk);
    #5 reset_n = 1;
    // CSR write, set and clear with read-back, unknown addresses included
    for (int i = 0; i < 60; i++) begin
      r = next_rand();
      case (r[3:0] % 9)
        0:       ca = CSR_MSTATUS;
        1:       ca = CSR_MIE;
        2:       ca = CSR_MTVEC;
        3:       ca = CSR_MSCRATCH;
        4:       ca = CSR_MEPC;
        5:       ca = CSR_MCAUSE;
        6:       ca = CSR_MIP;
        7:       ca = 12'h343;
        default: ca = r[27:16];
      endcase
      csr_access(csr_op_e'(r[31:8] % 3), ca, next_rand());
      csr_read_check(ca);
    end
    // CLINT accesses with random strobes over mapped and unmapped offsets
    for (int i = 0; i < 40; i++) begin
      r = next_rand();
      case (r[3:0] % 7)
        0:       a = CLINT_MSIP;
        1:       a = CLINT_MTIMECMP_LO;
        2:       a = CLINT_MTIMECMP_HI;
        3:       a = CLINT_MTIME_LO;
        4:       a = CLINT_MTIME_HI;
        5:       a = 16'h0004;
        default: a = 16'h8000;
      endcase
      if (r[4] && !(a inside {CLINT_MTIME_LO, CLINT_MTIME_HI})) begin
        d = next_rand();
        axi_write(a, d, r[11:8], (a inside {16'h0004, 16'h8000}) ? RESP_SLVERR : RESP_OKAY);
      end else begin
        axi_read(a, (a inside {16'h0004, 16'h8000}) ? RESP_SLVERR : RESP_OKAY, rd);
        case (a)
          CLINT_MSIP:        check_bus("rdata msip", rd, {31'd0, m_msip});
          CLINT_MTIMECMP_LO: check_bus("rdata mtimecmp_lo", rd, m_cmp[31:0]);
          CLINT_MTIMECMP_HI: check_bus("rdata mtimecmp_hi", rd, m_cmp[63:32]);
          CLINT_MTIME_HI:    check_bus("rdata mtime_hi", rd, '0);
          CLINT_MTIME_LO: begin
            check_bit("mtime_lo nondecreasing", rd >= last_time, 1'b1);
            check_bit("mtime_lo within cycle count", rd <= cycles, 1'b1);
            last_time = rd;
          end
          default:           check_bus("rdata unmapped", rd, '0);
        endcase
      end
    end
    axi_write(CLINT_MSIP, 32'd0, 4'hf, RESP_OKAY);
    axi_write(CLINT_MTIMECMP_LO, '1, 4'hf, RESP_OKAY);
    axi_write(CLINT_MTIMECMP_HI, '1, 4'hf, RESP_OKAY);
    // Software interrupt with random vector mode, then mret
    for (int i = 0; i < 3; i++) begin
      csr_access(csr_op_write, CSR_MTVEC, next_rand());
      csr_access(csr_op_write, CSR_MIE, 32'h8);
      csr_access(csr_op_write, CSR_MSTATUS, 32'h8);
      axi_write(CLINT_MSIP, 32'd1, 4'h1, RESP_OKAY);
      repeat (2) tick();                           // mip samples msip one cycle late
      take_trap(next_rand(), CAUSE_MSI);
      do_mret();
      axi_write(CLINT_MSIP, 32'd0, 4'h1, RESP_OKAY);
    end
    // Timer interrupt held off while MIE is clear
    csr_access(csr_op_write, CSR_MSTATUS, 32'h0);
    csr_access(csr_op_write, CSR_MIE, 32'h80);
    axi_write(CLINT_MTIMECMP_HI, 32'd0, 4'hf, RESP_OKAY);
    axi_write(CLINT_MTIMECMP_LO, axil_data_t'(cycles) + 32'd10, 4'hf, RESP_OKAY);
    retire_valid = 1'b1;
    repeat (30) begin
      #1;
      check_bit("trap_taken with MIE clear", trap_taken, 1'b0);
      tick();
    end
    retire_valid = 1'b0;
    csr_addr = CSR_MIP;                            // Compare has been reached by now
    #1;
    check_xlen("mip timer pending", csr_rdata, 32'h80);
    tick();
    csr_access(csr_op_write, CSR_MSTATUS, 32'h8);
    take_trap(next_rand(), CAUSE_MTI);
    do_mret();
    // All three sources pending, external wins and software follows
    csr_access(csr_op_write, CSR_MIE, 32'h888);
    axi_write(CLINT_MTIMECMP_LO, 32'd0, 4'hf, RESP_OKAY);
    axi_write(CLINT_MSIP, 32'd1, 4'h1, RESP_OKAY);
    irq_external = 1'b1;
    repeat (3) tick();
    take_trap(next_rand(), CAUSE_MEI);
    do_mret();
    irq_external = 1'b0;
    repeat (3) tick();
    take_trap(next_rand(), CAUSE_MSI);
    do_mret();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: sources.f
src/trap_pkg.sv
src/clint_pkg.sv
src/trap_if.sv
src/csr_file.sv
src/int_control.sv
src/clint_axil.sv
src/trap_unit_top.sv
verification/trap_unit_properties.sv
verification/tb_trap_unit.sv

// File: Bender.yml
package:
  name: trap_unit

sources:
  - src/trap_pkg.sv
  - src/clint_pkg.sv
  - src/trap_if.sv
  - src/csr_file.sv
  - src/int_control.sv
  - src/clint_axil.sv
  - src/trap_unit_top.sv
  - target: test
    files:
      - verification/trap_unit_properties.sv
      - verification/tb_trap_unit.sv
